/* design/smu_ctrl_pkg.sv */
// smu control block shared definitions
// field widths, spi frame layout, register map and the two presets

package smu_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths

  // one field register, low nibble of a write value is set, high is clear
  localparam int FIELD_W    = 4;
  localparam int ADDR_W     = 8;
  // address byte then value byte
  localparam int FRAME_BITS = 16;

  ////////////////////////////////////////////////////////////////////////////
  // frame and register types

  typedef struct packed {
    logic [ADDR_W-1:0]    addr;
    // {clear bits, set bits}
    logic [2*FIELD_W-1:0] value;
  } ctrl_frame_t;

  // first member lands in the msbs
  typedef struct packed {
    logic [FIELD_W-1:0] led;
    logic [FIELD_W-1:0] mux;
    logic [FIELD_W-1:0] dac;
    logic [FIELD_W-1:0] rails;
    logic [FIELD_W-1:0] adc;
    logic [FIELD_W-1:0] clamp1;
    logic [FIELD_W-1:0] relay_com;
    logic [FIELD_W-1:0] rails_oe;
  } ctrl_regs_t;

  ////////////////////////////////////////////////////////////////////////////
  // register map

  // command addresses, value byte ignored
  localparam logic [ADDR_W-1:0] ADDR_POWERUP    = 8'd6;
  localparam logic [ADDR_W-1:0] ADDR_SOFT_RESET = 8'd11;
  // field addresses
  localparam logic [ADDR_W-1:0] ADDR_LED        = 8'd7;
  localparam logic [ADDR_W-1:0] ADDR_MUX        = 8'd8;
  localparam logic [ADDR_W-1:0] ADDR_DAC        = 8'd9;
  localparam logic [ADDR_W-1:0] ADDR_RAILS      = 8'd10;
  localparam logic [ADDR_W-1:0] ADDR_ADC        = 8'd14;
  localparam logic [ADDR_W-1:0] ADDR_CLAMP1     = 8'd15;
  localparam logic [ADDR_W-1:0] ADDR_RELAY_COM  = 8'd17;
  // read only, sampled rail monitors
  localparam logic [ADDR_W-1:0] ADDR_MON_RAILS  = 8'd19;
  localparam logic [ADDR_W-1:0] ADDR_RAILS_OE   = 8'd24;

  ////////////////////////////////////////////////////////////////////////////
  // presets

  // clamps are active low so all ones is off
  // rails_oe active low, held high until rails come up
  localparam ctrl_regs_t SOFT_RESET_REGS = '{
    led:       '0,
    mux:       '0,
    dac:       '0,
    rails:     '0,
    adc:       '0,
    clamp1:    {FIELD_W{1'b1}},
    relay_com: '0,
    rails_oe:  FIELD_W'(1)
  };

  // +5V and +-15V rails on, outputs enabled
  // mux member not used, mux keeps its value on power-up
  localparam ctrl_regs_t POWERUP_REGS = '{
    led:       '0,
    mux:       '0,
    dac:       '0,
    rails:     FIELD_W'(3),
    adc:       '0,
    clamp1:    {FIELD_W{1'b1}},
    relay_com: '0,
    rails_oe:  '0
  };

endpackage

/* design/spi_frame_rx.sv */
// spi frame receiver, all in the clk domain
// oversamples the pins, collects 16 bit address/value frames, shifts read
// data out on sclk falling edges and hands frames on over a req/ack pair

`timescale 1ns/1ps

module spi_frame_rx (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                sclk,
  input  logic                                cs_n,
  input  logic                                mosi,
  input  logic                                frame_ack,
  input  logic [smu_ctrl_pkg::FIELD_W-1:0]    rd_value,
  output logic                                frame_req,
  output smu_ctrl_pkg::ctrl_frame_t           frame,
  output logic [smu_ctrl_pkg::ADDR_W-1:0]     rd_addr,
  output logic                                sdo
);

  import smu_ctrl_pkg::*;

  // room for one count past a full frame, then saturate
  localparam int                CNT_W    = $clog2(FRAME_BITS + 2);
  localparam logic [CNT_W-1:0] CNT_ADDR = CNT_W'(ADDR_W);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FRAME_BITS);
  localparam logic [CNT_W-1:0] CNT_OVER = CNT_W'(FRAME_BITS + 1);

  ////////////////////////////////////////////////////////////////////////////
  // pin synchronizers and edge detect

  // [1] is the synced level, [2] the level one clk earlier
  logic [2:0] sclk_p;
  logic [2:0] cs_p;
  logic [1:0] mosi_p;

  logic sclk_rise;
  logic sclk_fall;
  logic cs_rise;
  logic cs_idle;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      // idle bus, sclk low and cs high
      sclk_p <= '0;
      cs_p   <= '1;
      mosi_p <= '0;
    end
    else
    begin
      sclk_p <= {sclk_p[1:0], sclk};
      cs_p   <= {cs_p[1:0], cs_n};
      mosi_p <= {mosi_p[0], mosi};
    end
  end

  assign sclk_rise = sclk_p[1] & ~sclk_p[2];
  assign sclk_fall = ~sclk_p[1] & sclk_p[2];
  assign cs_rise   = cs_p[1] & ~cs_p[2];
  assign cs_idle   = cs_p[1];

  ////////////////////////////////////////////////////////////////////////////
  // deserializer

  logic [FRAME_BITS-1:0] rx_sr;
  logic [CNT_W-1:0]      bit_cnt;
  // read byte, zero nibble then field
  logic [2*FIELD_W-1:0]  tx_sr;

  // mosi into lsb, address ends up in the top byte
  always_ff @(posedge clk)
  begin
    if (sclk_rise && !cs_idle)
    begin
      rx_sr <= {rx_sr[FRAME_BITS-2:0], mosi_p[1]};
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      bit_cnt <= '0;
      rd_addr <= '0;
      tx_sr   <= '0;
    end
    else if (cs_idle)
    begin
      // between frames
      bit_cnt <= '0;
      tx_sr   <= '0;
    end
    else
    begin
      if (sclk_rise)
      begin
        if (bit_cnt != CNT_OVER)
        begin
          bit_cnt <= bit_cnt + 1'b1;
        end
        // 8th bit, address byte complete
        if (bit_cnt == CNT_ADDR - 1'b1)
        begin
          rd_addr <= {rx_sr[ADDR_W-2:0], mosi_p[1]};
        end
      end
      if (sclk_fall)
      begin
        // rd_value has settled by the falling edge after bit 8
        if (bit_cnt == CNT_ADDR)
        begin
          tx_sr <= {{FIELD_W{1'b0}}, rd_value};
        end
        else if (bit_cnt > CNT_ADDR)
        begin
          tx_sr <= {tx_sr[2*FIELD_W-2:0], 1'b0};
        end
      end
    end
  end

  // msb first, quiet while cs high
  assign sdo = tx_sr[2*FIELD_W-1] & ~cs_n;

  ////////////////////////////////////////////////////////////////////////////
  // handshake, req side

  // only a clean frame with both req and ack low is taken
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      frame_req <= 1'b0;
    end
    else if (frame_req && frame_ack)
    begin
      frame_req <= 1'b0;
    end
    else if (cs_rise && bit_cnt == CNT_FULL && !frame_req && !frame_ack)
    begin
      frame_req <= 1'b1;
    end
  end

  // held until the next accepted frame
  always_ff @(posedge clk)
  begin
    if (cs_rise && bit_cnt == CNT_FULL && !frame_req && !frame_ack)
    begin
      frame <= ctrl_frame_t'(rx_sr);
    end
  end

endmodule

/* design/ctrl_reg_file.sv */
// control register file
// eight 4 bit field registers with set/clear/toggle writes, soft reset and
// power-up presets, plus the led and rail monitor readback

`timescale 1ns/1ps

module ctrl_reg_file (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                frame_req,
  input  smu_ctrl_pkg::ctrl_frame_t           frame,
  input  logic [smu_ctrl_pkg::ADDR_W-1:0]     rd_addr,
  input  logic [smu_ctrl_pkg::FIELD_W-1:0]    mon_rails,
  output logic                                frame_ack,
  output logic [smu_ctrl_pkg::FIELD_W-1:0]    rd_value,
  output smu_ctrl_pkg::ctrl_regs_t            regs
);

  import smu_ctrl_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // field update rule

  // overlapping set and clear bits toggle, nothing else moves
  // otherwise set first, then clear
  function automatic logic [FIELD_W-1:0] field_update(
    input logic [FIELD_W-1:0]   cur,
    input logic [2*FIELD_W-1:0] val
  );
    logic [FIELD_W-1:0] set_bits;
    logic [FIELD_W-1:0] clr_bits;
    logic [FIELD_W-1:0] both;
    set_bits = val[FIELD_W-1:0];
    clr_bits = val[2*FIELD_W-1:FIELD_W];
    both     = set_bits & clr_bits;
    if (|both)
    begin
      return cur ^ both;
    end
    return (cur | set_bits) & ~clr_bits;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // handshake, ack side

  logic       accept;
  ctrl_regs_t next_regs;

  // first cycle of req high with ack low
  assign accept = frame_req & ~frame_ack;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      frame_ack <= 1'b0;
    end
    else if (accept)
    begin
      frame_ack <= 1'b1;
    end
    else if (!frame_req)
    begin
      // req gone, close out the cycle
      frame_ack <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // register writes

  always_comb
  begin
    next_regs = regs;
    case (frame.addr)
      ADDR_LED:       next_regs.led       = field_update(regs.led, frame.value);
      ADDR_MUX:       next_regs.mux       = field_update(regs.mux, frame.value);
      ADDR_DAC:       next_regs.dac       = field_update(regs.dac, frame.value);
      ADDR_RAILS:     next_regs.rails     = field_update(regs.rails, frame.value);
      ADDR_ADC:       next_regs.adc       = field_update(regs.adc, frame.value);
      ADDR_CLAMP1:    next_regs.clamp1    = field_update(regs.clamp1, frame.value);
      ADDR_RELAY_COM: next_regs.relay_com = field_update(regs.relay_com, frame.value);
      ADDR_RAILS_OE:  next_regs.rails_oe  = field_update(regs.rails_oe, frame.value);
      ADDR_SOFT_RESET:
      begin
        // same state as after rst
        next_regs = SOFT_RESET_REGS;
      end
      ADDR_POWERUP:
      begin
        next_regs     = POWERUP_REGS;
        // don't disturb peripheral muxing mid session
        next_regs.mux = regs.mux;
      end
      default:
      begin
        // unmapped or read only, no change
        next_regs = regs;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      regs <= SOFT_RESET_REGS;
    end
    else if (accept)
    begin
      regs <= next_regs;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // readback

  logic [FIELD_W-1:0] mon_q;

  // rail monitor pins, sampled every cycle
  always_ff @(posedge clk)
  begin
    mon_q <= mon_rails;
  end

  always_comb
  begin
    case (rd_addr)
      ADDR_LED:       rd_value = regs.led;
      ADDR_MON_RAILS: rd_value = mon_q;
      default:        rd_value = '0;
    endcase
  end

endmodule

/* design/spi_route.sv */
// spi chip select and miso steering
// mux_cs_n low hands the bus to the peripherals picked by the mux field,
// high keeps it on the block itself

`timescale 1ns/1ps

module spi_route #(
  parameter int PERIPH_COUNT = 4
) (
  input  logic                              mux_cs_n,
  input  logic [smu_ctrl_pkg::FIELD_W-1:0]  mux_sel,
  input  logic                              sdo,
  input  logic [PERIPH_COUNT-1:0]           periph_miso,
  output logic [PERIPH_COUNT-1:0]           periph_cs_n,
  output logic                              miso
);

  import smu_ctrl_pkg::*;

  // one select bit per peripheral, missing mux bits read as unselected
  logic [PERIPH_COUNT-1:0] sel;

  for (genvar i = 0; i < PERIPH_COUNT; i++)
  begin : g_sel
    if (i < FIELD_W)
    begin : g_bit
      assign sel[i] = mux_sel[i];
    end
    else
    begin : g_pad
      assign sel[i] = 1'b0;
    end
  end

  // active low selects, all off while mux_cs_n is high
  assign periph_cs_n = mux_cs_n ? {PERIPH_COUNT{1'b1}} : ~sel;

  // wired-or of whatever is selected
  assign miso = mux_cs_n ? sdo : |(sel & periph_miso);

endmodule

/* design/smu_ctrl_top.sv */
// smu front end configuration block
// spi frame receiver feeding the control register file, with chip select
// and miso routing to the peripherals

`timescale 1ns/1ps

module smu_ctrl_top #(
  parameter int PERIPH_COUNT = 4
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              sclk,
  input  logic                              cs_n,
  input  logic                              mosi,
  input  logic                              mux_cs_n,
  input  logic [PERIPH_COUNT-1:0]           periph_miso,
  input  logic [smu_ctrl_pkg::FIELD_W-1:0]  mon_rails,
  output logic                              miso,
  output logic [PERIPH_COUNT-1:0]           periph_cs_n,
  output smu_ctrl_pkg::ctrl_regs_t          regs
);

  import smu_ctrl_pkg::*;

  // receiver to register file
  logic                frame_req;
  logic                frame_ack;
  ctrl_frame_t         frame;
  logic [ADDR_W-1:0]   rd_addr;
  logic [FIELD_W-1:0]  rd_value;
  // block's own read data, before routing
  logic                sdo;

  ////////////////////////////////////////////////////////////////////////////
  // frame receiver

  spi_frame_rx u_rx (
    .clk       (clk),
    .rst       (rst),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .frame_ack (frame_ack),
    .rd_value  (rd_value),
    .frame_req (frame_req),
    .frame     (frame),
    .rd_addr   (rd_addr),
    .sdo       (sdo)
  );

  ////////////////////////////////////////////////////////////////////////////
  // field registers

  ctrl_reg_file u_regs (
    .clk       (clk),
    .rst       (rst),
    .frame_req (frame_req),
    .frame     (frame),
    .rd_addr   (rd_addr),
    .mon_rails (mon_rails),
    .frame_ack (frame_ack),
    .rd_value  (rd_value),
    .regs      (regs)
  );

  ////////////////////////////////////////////////////////////////////////////
  // peripheral routing

  spi_route #(
    .PERIPH_COUNT (PERIPH_COUNT)
  ) u_route (
    .mux_cs_n    (mux_cs_n),
    .mux_sel     (regs.mux),
    .sdo         (sdo),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .miso        (miso)
  );

endmodule

/* verification/smu_ctrl_props.sv */
// frame handshake checks on the control register file
// bound into every ctrl_reg_file instance

`timescale 1ns/1ps

module smu_ctrl_props (
  input logic                       clk,
  input logic                       rst,
  input logic                       frame_req,
  input logic                       frame_ack,
  input smu_ctrl_pkg::ctrl_frame_t  frame
);

  // running count of failed assertions
  int assert_fails = 0;

  // frame held while req stays up
  frame_stable_a : assert property (
    @(posedge clk) disable iff (rst)
    (frame_req && $past(frame_req)) |-> $stable(frame)
  )
  else
  begin
    assert_fails = assert_fails + 1;
    $error("frame changed while frame_req was high");
  end

  // ack only answers a live req
  ack_rise_a : assert property (
    @(posedge clk) disable iff (rst)
    $rose(frame_ack) |-> frame_req
  )
  else
  begin
    assert_fails = assert_fails + 1;
    $error("frame_ack rose with frame_req low");
  end

  // ack drops one cycle after req is seen low
  ack_fall_a : assert property (
    @(posedge clk) disable iff (rst)
    $fell(frame_ack) |-> !$past(frame_req)
  )
  else
  begin
    assert_fails = assert_fails + 1;
    $error("frame_ack fell before frame_req went low");
  end

endmodule

bind ctrl_reg_file smu_ctrl_props u_props (
  .clk       (clk),
  .rst       (rst),
  .frame_req (frame_req),
  .frame_ack (frame_ack),
  .frame     (frame)
);

/* verification/smu_ctrl_tb.sv */
// testbench for the smu control block
// bit-banged spi frames, a register model and directed tests for writes,
// presets, readback and peripheral routing

`timescale 1ns/1ps

module smu_ctrl_tb;

  import smu_ctrl_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int PERIPH_COUNT = 4;
  // clk cycles per sclk half period, clk/16 sclk
  localparam int HALF         = 8;
  // wait after cs_n rises before looking at regs
  localparam int SETTLE       = 10;
  // one frame: setup, bits, hold, settle
  localparam int FRAME_CYCLES = 1 + 2 * HALF + 2 * HALF * FRAME_BITS + SETTLE;
  // frames sent over all tests
  localparam int FRAME_COUNT  = 42;
  localparam int WATCHDOG_NS  = 2 * (FRAME_COUNT * FRAME_CYCLES + 100) * CLK_PERIOD;

  logic                    clk;
  logic                    rst;
  logic                    sclk;
  logic                    cs_n;
  logic                    mosi;
  logic                    mux_cs_n;
  logic [PERIPH_COUNT-1:0] periph_miso;
  logic [FIELD_W-1:0]      mon_rails;
  logic                    miso;
  logic [PERIPH_COUNT-1:0] periph_cs_n;
  ctrl_regs_t              regs;

  ctrl_regs_t  model;
  logic [15:0] last_rx;
  logic [31:0] lfsr = 32'hb72ed645;
  int          checks = 0;
  int          errors = 0;

  smu_ctrl_top #(
    .PERIPH_COUNT (PERIPH_COUNT)
  ) UUT (
    .clk         (clk),
    .rst         (rst),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .mux_cs_n    (mux_cs_n),
    .periph_miso (periph_miso),
    .mon_rails   (mon_rails),
    .miso        (miso),
    .periph_cs_n (periph_cs_n),
    .regs        (regs)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired at %0t, the tests did not finish in time", $time);
    $display("TEST FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // random source and register model

  // galois lfsr, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b)
      begin
        lfsr = lfsr ^ 32'h8020_0003;
      end
      r = {r[30:0], b};
    end
    return r;
  endfunction

  function automatic ctrl_regs_t reset_image();
    ctrl_regs_t r;
    r          = '0;
    r.clamp1   = 4'hf;
    r.rails_oe = 4'h1;
    return r;
  endfunction

  function automatic ctrl_regs_t powerup_image();
    ctrl_regs_t r;
    r        = '0;
    r.rails  = 4'h3;
    r.clamp1 = 4'hf;
    return r;
  endfunction

  // low nibble sets, high nibble clears, overlap toggles only the overlap
  function automatic logic [3:0] expect_field(input logic [3:0] cur, input logic [7:0] value);
    logic [3:0] set_bits;
    logic [3:0] clr_bits;
    logic [3:0] res;
    logic [3:0] m;
    logic       overlap;
    set_bits = value[3:0];
    clr_bits = value[7:4];
    overlap  = (set_bits & clr_bits) != '0;
    res      = cur;
    for (int b = 0; b < FIELD_W; b++)
    begin
      m = 4'b0001 << b;
      if (overlap && (set_bits & m) != '0 && (clr_bits & m) != '0)
      begin
        res = res ^ m;
      end
      else if (!overlap && (set_bits & m) != '0)
      begin
        res = res | m;
      end
      // clear after set
      if (!overlap && (clr_bits & m) != '0)
      begin
        res = res & ~m;
      end
    end
    return res;
  endfunction

  function automatic ctrl_regs_t model_frame(input ctrl_regs_t cur, input logic [7:0] addr,
                                             input logic [7:0] value);
    ctrl_regs_t nxt;
    nxt = cur;
    case (addr)
      ADDR_LED:        nxt.led       = expect_field(cur.led, value);
      ADDR_MUX:        nxt.mux       = expect_field(cur.mux, value);
      ADDR_DAC:        nxt.dac       = expect_field(cur.dac, value);
      ADDR_RAILS:      nxt.rails     = expect_field(cur.rails, value);
      ADDR_ADC:        nxt.adc       = expect_field(cur.adc, value);
      ADDR_CLAMP1:     nxt.clamp1    = expect_field(cur.clamp1, value);
      ADDR_RELAY_COM:  nxt.relay_com = expect_field(cur.relay_com, value);
      ADDR_RAILS_OE:   nxt.rails_oe  = expect_field(cur.rails_oe, value);
      ADDR_SOFT_RESET: nxt = reset_image();
      ADDR_POWERUP:
      begin
        nxt     = powerup_image();
        nxt.mux = cur.mux;
      end
      default:         nxt = cur;
    endcase
    return nxt;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // driver and checks

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp)
    begin
      errors = errors + 1;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // msb first from data[15], miso sampled late in each high half
  task automatic spi_xfer(input logic [15:0] data, input int nbits);
    logic [15:0] sh;
    sh      = data;
    last_rx = '0;
    @(posedge clk);
    cs_n <= 1'b0;
    repeat (HALF) @(posedge clk);
    for (int i = 0; i < nbits; i++)
    begin
      sclk <= 1'b0;
      mosi <= sh[15];
      sh = sh << 1;
      repeat (HALF) @(posedge clk);
      sclk <= 1'b1;
      repeat (HALF - 1) @(posedge clk);
      @(negedge clk);
      last_rx = {last_rx[14:0], miso};
      @(posedge clk);
    end
    sclk <= 1'b0;
    repeat (HALF) @(posedge clk);
    cs_n <= 1'b1;
    repeat (SETTLE) @(posedge clk);
  endtask

  task automatic write_frame(input logic [7:0] addr, input logic [7:0] value);
    model = model_frame(model, addr, value);
    spi_xfer({addr, value}, FRAME_BITS);
    @(negedge clk);
    check_val("regs", regs, model);
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before)
    begin
      $display("%s: ok", name);
    end
    else
    begin
      $display("%s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  // periph_cs_n and miso against every periph_miso pattern
  task automatic check_routing();
    logic [3:0] exp_cs;
    logic [3:0] m;
    logic       exp_miso;
    for (int v = 0; v < 16; v++)
    begin
      @(posedge clk);
      periph_miso <= 4'(v);
      @(negedge clk);
      exp_cs   = 4'hf;
      exp_miso = 1'b0;
      for (int b = 0; b < PERIPH_COUNT; b++)
      begin
        m = 4'b0001 << b;
        if ((model.mux & m) != '0)
        begin
          exp_cs = exp_cs & ~m;
          if ((4'(v) & m) != '0)
          begin
            exp_miso = 1'b1;
          end
        end
      end
      check_val("periph_cs_n", 32'(periph_cs_n), 32'(exp_cs));
      check_val("miso", 32'(miso), 32'(exp_miso));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests

  task automatic test_reset_state();
    int err0;
    err0 = errors;
    @(negedge clk);
    check_val("regs", regs, reset_image());
    check_val("periph_cs_n", 32'(periph_cs_n), 32'hf);
    check_val("frame_req", 32'(UUT.frame_req), 32'h0);
    check_val("frame_ack", 32'(UUT.frame_ack), 32'h0);
    report_test("reset state", err0);
  endtask

  task automatic test_random_writes();
    int         err0;
    logic [7:0] addrs[8];
    err0  = errors;
    addrs = '{ADDR_LED, ADDR_MUX, ADDR_DAC, ADDR_RAILS,
              ADDR_ADC, ADDR_CLAMP1, ADDR_RELAY_COM, ADDR_RAILS_OE};
    foreach (addrs[i])
    begin
      repeat (3)
      begin
        write_frame(addrs[i], 8'(rand_bits(8)));
      end
    end
    report_test("random field writes", err0);
  endtask

  task automatic test_toggle();
    int err0;
    err0 = errors;
    write_frame(ADDR_DAC, 8'hf0);
    check_val("regs.dac", 32'(regs.dac), 32'h0);
    write_frame(ADDR_DAC, 8'h05);
    check_val("regs.dac", 32'(regs.dac), 32'h5);
    // bit 1 in both nibbles, only bit 1 flips
    write_frame(ADDR_DAC, 8'h36);
    check_val("regs.dac", 32'(regs.dac), 32'h7);
    write_frame(ADDR_DAC, 8'h55);
    check_val("regs.dac", 32'(regs.dac), 32'h2);
    report_test("overlap toggle", err0);
  endtask

  task automatic test_presets();
    int         err0;
    ctrl_regs_t exp;
    err0 = errors;
    write_frame(ADDR_MUX, 8'hf0);
    write_frame(ADDR_MUX, 8'h0a);
    write_frame(ADDR_POWERUP, 8'(rand_bits(8)));
    exp     = powerup_image();
    exp.mux = 4'ha;
    check_val("regs", regs, exp);
    write_frame(ADDR_SOFT_RESET, 8'(rand_bits(8)));
    check_val("regs", regs, reset_image());
    report_test("power-up and soft reset", err0);
  endtask

  task automatic test_readback();
    int         err0;
    logic [3:0] mon;
    err0 = errors;
    mon  = 4'(rand_bits(4));
    @(posedge clk);
    mon_rails <= mon;
    write_frame(ADDR_LED, 8'h09);
    // value 0 neither sets nor clears
    write_frame(ADDR_LED, 8'h00);
    check_val("miso byte", 32'(last_rx), 32'(model.led));
    write_frame(ADDR_MON_RAILS, 8'h00);
    check_val("miso byte", 32'(last_rx), 32'(mon));
    write_frame(8'h42, 8'h00);
    check_val("miso byte", 32'(last_rx), 32'h0);
    // short frame is dropped
    // its 12 bits land as a led clear if the receiver takes them
    spi_xfer(16'h7f00, 12);
    @(negedge clk);
    check_val("regs", regs, model);
    write_frame(ADDR_LED, 8'h00);
    check_val("miso byte", 32'(last_rx), 32'(model.led));
    report_test("readback and short frame", err0);
  endtask

  task automatic test_routing();
    int err0;
    err0 = errors;
    write_frame(ADDR_MUX, 8'hf0);
    write_frame(ADDR_MUX, 8'h05);
    @(posedge clk);
    mux_cs_n <= 1'b0;
    check_routing();
    @(posedge clk);
    mux_cs_n <= 1'b1;
    write_frame(ADDR_MUX, 8'h5a);
    @(posedge clk);
    mux_cs_n <= 1'b0;
    check_routing();
    // back to the block, peripherals all driving high
    @(posedge clk);
    mux_cs_n    <= 1'b1;
    periph_miso <= '1;
    @(negedge clk);
    check_val("periph_cs_n", 32'(periph_cs_n), 32'hf);
    check_val("miso", 32'(miso), 32'h0);
    write_frame(ADDR_LED, 8'h00);
    check_val("miso byte", 32'(last_rx), 32'(model.led));
    report_test("peripheral routing", err0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial
  begin
    rst         = 1'b1;
    sclk        = 1'b0;
    cs_n        = 1'b1;
    mosi        = 1'b0;
    mux_cs_n    = 1'b1;
    periph_miso = '0;
    mon_rails   = '0;
    model       = reset_image();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    test_reset_state();
    test_random_writes();
    test_toggle();
    test_presets();
    test_readback();
    test_routing();
    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, UUT.u_regs.u_props.assert_fails);
    if (errors == 0 && UUT.u_regs.u_props.assert_fails == 0)
    begin
      $display("TEST PASS");
    end
    else
    begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* verilog.f */
design/smu_ctrl_pkg.sv
design/spi_frame_rx.sv
design/ctrl_reg_file.sv
design/spi_route.sv
design/smu_ctrl_top.sv
verification/smu_ctrl_props.sv
verification/smu_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module smu_ctrl_tb -f verilog.f -o smu_ctrl_sim &&
  ./obj_dir/smu_ctrl_sim +verilator+error+limit+1000 > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "TEST PASS" sim.log && echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
